// ==== sources.f ====
design/smpc_bus_pkg.sv
design/smpc_cmd_pkg.sv
design/smpc_host_regs.sv
design/smpc_cmd_ctrl.sv
design/smpc_rtc.sv
design/smpc_status_bank.sv
design/smpc_oreg_ram.sv
design/smpc_top.sv
verif/smpc_tb.sv

// ==== verif/smpc_tb.sv ====
module smpc_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import smpc_cmd_pkg::*;

	// Host register addresses as seen on A[6:1]
	localparam logic [5:0] A_IREG0  = 6'h00;
	localparam logic [5:0] A_IREG1  = 6'h01;
	localparam logic [5:0] A_IREG2  = 6'h02;
	localparam logic [5:0] A_IREG3  = 6'h03;
	localparam logic [5:0] A_COMREG = 6'h0F;
	localparam logic [5:0] A_OREG0  = 6'h10;
	localparam logic [5:0] A_SR     = 6'h30;
	localparam logic [5:0] A_SF     = 6'h31;

	// Pin order {mshres, mshnmi, sshres, sshnmi, sysres, sndres, cdres}
	localparam logic [6:0] LINES_AT_RESET = 7'b1101101;

	logic       CLK = 1'b0;
	logic       RST_N;
	logic [5:0] a;
	logic [7:0] di;
	logic       cs_n;
	logic       rw_n;
	logic [7:0] do_byte;
	logic       mirq_n, mshres_n, mshnmi_n, sshres_n, sshnmi_n, sysres_n, sndres_n, cdres_n;
	logic [6:0] pins;
	logic [7:0] watch, watch_prev;

	int         cycle_cnt = 0;
	int         fall_cnt [8];  // index 7 is MIRQ_N
	int         snap [8];
	int         err_cnt = 0;
	int         tests_run = 0;
	int         tests_failed = 0;
	int         seed = 32'h10da_3a7e;
	logic [6:0] exp_lines;
	logic [7:0] oreg [32];

	assign pins  = {mshres_n, mshnmi_n, sshres_n, sshnmi_n, sysres_n, sndres_n, cdres_n};
	assign watch = {mirq_n, pins};

	smpc_top #(.SEC_DIV(4)) dut (
		.CLK(CLK), .RST_N(RST_N), .a(a), .di(di), .cs_n(cs_n), .rw_n(rw_n), .area(4'h4),
		.do_byte(do_byte), .mirq_n(mirq_n), .mshres_n(mshres_n), .mshnmi_n(mshnmi_n),
		.sshres_n(sshres_n), .sshnmi_n(sshnmi_n), .sysres_n(sysres_n),
		.sndres_n(sndres_n), .cdres_n(cdres_n)
	);

	always #20 CLK = ~CLK;

	always @(posedge CLK)
		if (RST_N) cycle_cnt <= cycle_cnt + 1;

	// Falling edges sampled mid-cycle
	always @(negedge CLK) begin
		if (RST_N)
			for (int i = 0; i < 8; i++)
				if (watch_prev[i] && !watch[i]) fall_cnt[i] = fall_cnt[i] + 1;
		watch_prev = watch;
	end

	function automatic logic [7:0] ref_status(input int idx, input logic ste, input logic resd,
			input logic [3:0] ar, input logic [6:0] lines, input logic [31:0] smem,
			input logic [7:0] cmd);
		logic [7:0] r;
		r = 8'h00;
		case (idx)
			0: begin
				r[7] = ste;
				r[6] = resd;
			end
			1: r = 8'h20;  // year 2022, month 1
			2: r = 8'h22;
			3: r = 8'h01;
			9: r[3:0] = ar;
			10: begin
				r[5] = 1'b1;
				r[4] = 1'b1;
				r[3] = ~lines[5];  // MSHNMI
				r[2] = 1'b1;
				r[1] = ~lines[2];  // SYSRES
				r[0] = ~lines[1];  // SNDRES
			end
			11: r[6] = ~lines[0];
			12, 13, 14, 15: r = smem[8*(idx-12) +: 8];
			31: r = cmd;
			default: r = 8'h00;
		endcase
		return r;
	endfunction

	function automatic int bcd_val(input logic [7:0] b);
		return b[7:4] * 10 + b[3:0];
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic cycles(input int n);
		repeat (n) @(posedge CLK);
		#2;
	endtask

	task automatic give_up(input string why);
		$display("Timeout: %s", why);
		$display("Test failures found");
		$finish;
	endtask

	task automatic host_write(input logic [5:0] addr, input logic [7:0] data);
		a    = addr;
		di   = data;
		cs_n = 1'b0;
		cycles(3);
		rw_n = 1'b0;  // write strobe
		cycles(3);
		rw_n = 1'b1;
		cs_n = 1'b1;
		cycles(3);
	endtask

	task automatic host_read(input logic [5:0] addr, output logic [7:0] data);
		a    = addr;
		rw_n = 1'b1;
		cs_n = 1'b0;
		cycles(3);
		data = do_byte;
		cs_n = 1'b1;
		cycles(3);
	endtask

	task automatic run_cmd(input logic [7:0] code, output int t_write, output int t_clear);
		logic [7:0] val;
		logic       busy;
		host_write(A_SF, 8'h01);
		host_write(A_COMREG, code);
		t_write = cycle_cnt;
		busy = 1'b1;
		while (busy) begin
			host_read(A_SF, val);
			if (!val[0])
				busy = 1'b0;
			else if (cycle_cnt - t_write > 5000)
				give_up($sformatf("SF never cleared for command %02h", code));
		end
		t_clear = cycle_cnt;
	endtask

	task automatic line_cmd(input logic [7:0] code, input int idx, input logic level);
		int t0, t1;
		run_cmd(code, t0, t1);
		exp_lines[idx] = level;
		check($sformatf("pins after command %02h", code), pins, exp_lines);
	endtask

	task automatic take_snapshot();
		for (int i = 0; i < 8; i++)
			snap[i] = fall_cnt[i];
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests_run++;
		if (err_cnt == errs_before) begin
			$display("%s: passed", name);
		end else begin
			$display("%s: FAILED", name);
			tests_failed++;
		end
	endtask

	initial begin
		logic [7:0]  val;
		logic [31:0] smem;
		logic [7:0]  ireg1;
		int          e0, t0, t1, secs;
		RST_N = 1'b0;
		a     = '0;
		di    = '0;
		cs_n  = 1'b1;
		rw_n  = 1'b1;
		watch_prev = '1;
		for (int i = 0; i < 8; i++)
			fall_cnt[i] = 0;
		cycles(8);
		RST_N = 1'b1;
		cycles(2);

		e0 = err_cnt;
		exp_lines = LINES_AT_RESET;
		check("reset pins", pins, exp_lines);
		check("MIRQ_N after reset", mirq_n, 1'b1);
		check("DO after reset", do_byte, 8'h00);
		host_read(A_SF, val);
		check("SF after reset", val, 8'h00);
		host_read(A_SR, val);
		check("SR after reset", val, 8'h00);
		end_test("reset state", e0);

		e0 = err_cnt;
		line_cmd(CMD_SSHON, 4, 1'b1);
		line_cmd(CMD_SNDON, 1, 1'b1);
		line_cmd(CMD_CDOFF, 0, 1'b0);
		line_cmd(CMD_CDON, 0, 1'b1);
		line_cmd(CMD_SSHOFF, 4, 1'b0);
		line_cmd(CMD_SNDOFF, 1, 1'b0);
		line_cmd(CMD_MSHON, 6, 1'b1);
		line_cmd(CMD_SSHON, 4, 1'b1);
		line_cmd(CMD_SNDON, 1, 1'b1);
		take_snapshot();
		run_cmd(CMD_SYSRES, t0, t1);
		for (int i = 0; i < 7; i++)
			check($sformatf("SYSRES pulses on pin %0d", i), fall_cnt[i] - snap[i], 1);
		check("pins after SYSRES", pins, 7'h7F);
		take_snapshot();
		run_cmd(CMD_NMIREQ, t0, t1);
		for (int i = 0; i < 7; i++)
			check($sformatf("NMIREQ pulses on pin %0d", i), fall_cnt[i] - snap[i],
				(i == 5) ? 1 : 0);
		check("pins after NMIREQ", pins, 7'h7F);
		exp_lines = 7'h7F;
		end_test("reset line commands", e0);

		e0 = err_cnt;
		smem = $random(seed);
		host_write(A_IREG0, smem[7:0]);
		host_write(A_IREG1, smem[15:8]);
		host_write(A_IREG2, smem[23:16]);
		host_write(A_IREG3, smem[31:24]);
		run_cmd(CMD_SETSMEM, t0, t1);
		run_cmd(CMD_RESENAB, t0, t1);
		run_cmd(CMD_SETTIME, t0, t1);
		ireg1 = 8'($random(seed));
		host_write(A_IREG0, 8'h01);
		host_write(A_IREG1, ireg1);
		host_write(A_IREG2, 8'hF0);
		take_snapshot();
		run_cmd(CMD_INTBACK, t0, t1);
		for (int i = 0; i < 32; i++)
			host_read(A_OREG0 + 6'(i), oreg[i]);
		for (int i = 0; i < 32; i++)
			if (i < 4 || i > 7)
				check($sformatf("OREG%0d", i), oreg[i],
					ref_status(i, 1'b1, 1'b0, 4'h4, exp_lines, smem, CMD_INTBACK));
		host_read(A_SR, val);
		check("SR", val, {3'b010, 1'b0, ireg1[7:4]});
		check("MIRQ_N pulses", fall_cnt[7] - snap[7], 1);
		end_test("status INTBACK", e0);

		e0 = err_cnt;
		for (int i = 4; i < 8; i++)
			check($sformatf("OREG%0d is BCD", i),
				(oreg[i][7:4] <= 4'd9) && (oreg[i][3:0] <= 4'd9), 1'b1);
		secs = ((bcd_val(oreg[4]) * 24 + bcd_val(oreg[5])) * 60 + bcd_val(oreg[6])) * 60
			+ bcd_val(oreg[7]);
		check("clock not before command", secs >= t0 / 4, 1'b1);
		check("clock not after SF clear", secs <= t1 / 4, 1'b1);
		end_test("clock bytes", e0);

		e0 = err_cnt;
		run_cmd(CMD_RESDISA, t0, t1);
		host_read(A_OREG0 + 6'd31, val);
		check("OREG31 after RESDISA", val, CMD_RESDISA);
		host_write(A_IREG0, 8'h00);
		take_snapshot();
		run_cmd(CMD_INTBACK, t0, t1);
		host_read(A_OREG0 + 6'd31, val);
		check("OREG31 after plain INTBACK", val, CMD_INTBACK);
		check("MIRQ_N pulses", fall_cnt[7] - snap[7], 0);
		end_test("INTBACK without status", e0);

		$display("Tests run %0d, failed %0d, failed checks %0d", tests_run, tests_failed,
			err_cnt);
		if (err_cnt == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== design/smpc_top.sv ====
module smpc_top #(
	parameter int unsigned SEC_DIV = 4000000
) (
	input  logic                     CLK,
	input  logic                     RST_N,
	input  smpc_bus_pkg::reg_addr_t  a,
	input  smpc_bus_pkg::byte_t      di,
	input  logic                     cs_n,
	input  logic                     rw_n,
	input  logic [3:0]               area,
	output smpc_bus_pkg::byte_t      do_byte,
	output logic                     mirq_n,
	output logic                     mshres_n,
	output logic                     mshnmi_n,
	output logic                     sshres_n,
	output logic                     sshnmi_n,
	output logic                     sysres_n,
	output logic                     sndres_n,
	output logic                     cdres_n
);
	import smpc_bus_pkg::*;
	import smpc_cmd_pkg::*;

	ireg_t        ireg;
	cmd_t         comreg;
	logic         cmd_go;
	logic         cmd_done;
	logic [2:0]   sr_hi;
	reset_lines_t reset_lines;
	logic         oreg_we;
	oreg_idx_t    oreg_wa;
	oreg_idx_t    oreg_sel;
	oreg_idx_t    oreg_ra;
	byte_t        oreg_q;
	byte_t        status_byte;
	bcd_time_t    rtc_time;
	logic         smem_load, set_ste, res_enable, res_disable;

	smpc_host_regs u_host_regs (
		.CLK(CLK), .RST_N(RST_N), .a(a), .di(di), .cs_n(cs_n), .rw_n(rw_n),
		.oreg_q(oreg_q), .cmd_done(cmd_done), .sr_hi(sr_hi), .do_byte(do_byte),
		.ireg(ireg), .comreg(comreg), .cmd_go(cmd_go), .oreg_ra(oreg_ra)
	);

	smpc_cmd_ctrl u_cmd_ctrl (
		.CLK(CLK), .RST_N(RST_N), .cmd_go(cmd_go), .comreg(comreg), .ireg(ireg),
		.reset_lines(reset_lines), .mirq_n(mirq_n), .sr_hi(sr_hi), .cmd_done(cmd_done),
		.oreg_we(oreg_we), .oreg_wa(oreg_wa), .oreg_sel(oreg_sel), .smem_load(smem_load),
		.set_ste(set_ste), .res_enable(res_enable), .res_disable(res_disable)
	);

	smpc_status_bank u_status_bank (
		.CLK(CLK), .RST_N(RST_N), .ireg(ireg), .area(area), .rtc_time(rtc_time),
		.reset_lines(reset_lines), .oreg_sel(oreg_sel), .comreg(comreg),
		.smem_load(smem_load), .set_ste(set_ste), .res_enable(res_enable),
		.res_disable(res_disable), .status_byte(status_byte)
	);

	smpc_rtc #(.SEC_DIV(SEC_DIV)) u_rtc (.CLK(CLK), .RST_N(RST_N), .rtc_time(rtc_time));

	smpc_oreg_ram u_oreg_ram (
		.CLK(CLK), .we(oreg_we), .wa(oreg_wa), .wd(status_byte), .ra(oreg_ra), .q(oreg_q)
	);

	assign mshres_n = reset_lines.mshres_n;
	assign mshnmi_n = reset_lines.mshnmi_n;
	assign sshres_n = reset_lines.sshres_n;
	assign sshnmi_n = reset_lines.sshnmi_n;
	assign sysres_n = reset_lines.sysres_n;
	assign sndres_n = reset_lines.sndres_n;
	assign cdres_n  = reset_lines.cdres_n;

endmodule

// ==== design/smpc_oreg_ram.sv ====
module smpc_oreg_ram (
	input  logic                     CLK,
	input  logic                     we,
	input  smpc_bus_pkg::oreg_idx_t  wa,
	input  smpc_bus_pkg::byte_t      wd,
	input  smpc_bus_pkg::oreg_idx_t  ra,
	output smpc_bus_pkg::byte_t      q
);
	import smpc_bus_pkg::*;

	byte_t mem [32];

	always_ff @(posedge CLK) begin
		if (we)
			mem[wa] <= wd;
	end

	assign q = mem[ra];  // async read

endmodule

// ==== design/smpc_status_bank.sv ====
module smpc_status_bank (
	input  logic                        CLK,
	input  logic                        RST_N,
	input  smpc_bus_pkg::ireg_t         ireg,
	input  logic [3:0]                  area,
	input  smpc_cmd_pkg::bcd_time_t     rtc_time,
	input  smpc_cmd_pkg::reset_lines_t  reset_lines,
	input  smpc_bus_pkg::oreg_idx_t     oreg_sel,
	input  smpc_cmd_pkg::cmd_t          comreg,
	input  logic                        smem_load,
	input  logic                        set_ste,
	input  logic                        res_enable,
	input  logic                        res_disable,
	output smpc_bus_pkg::byte_t         status_byte
);
	import smpc_bus_pkg::*;
	import smpc_cmd_pkg::*;

	byte_t smem [4];
	logic  ste;
	logic  resd;

	always_ff @(posedge CLK) begin
		if (smem_load) begin
			smem[0] <= ireg.ireg0;
			smem[1] <= ireg.ireg1;
			smem[2] <= ireg.ireg2;
			smem[3] <= ireg.ireg3;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ste  <= 1'b0;
			resd <= 1'b1;  // reset button NMI disabled
		end else begin
			if (set_ste)
				ste <= 1'b1;
			if (res_enable)
				resd <= 1'b0;
			else if (res_disable)
				resd <= 1'b1;
		end
	end

	always_comb begin
		case (oreg_sel)
			5'd0:  status_byte = {ste, resd, 6'b000000};
			5'd1:  status_byte = STATUS_YEAR_HI;
			5'd2:  status_byte = STATUS_YEAR_LO;
			5'd3:  status_byte = STATUS_MONTH;
			5'd4:  status_byte = rtc_time.day;
			5'd5:  status_byte = rtc_time.hour;
			5'd6:  status_byte = rtc_time.min;
			5'd7:  status_byte = rtc_time.sec;
			5'd9:  status_byte = {4'b0000, area};
			// Dot clock select is always 0
			5'd10: status_byte = {2'b00, 2'b11, ~reset_lines.mshnmi_n, 1'b1,
				~reset_lines.sysres_n, ~reset_lines.sndres_n};
			5'd11: status_byte = {1'b0, ~reset_lines.cdres_n, 6'b000000};
			5'd12: status_byte = smem[0];
			5'd13: status_byte = smem[1];
			5'd14: status_byte = smem[2];
			5'd15: status_byte = smem[3];
			5'd31: status_byte = byte_t'(comreg);
			default: status_byte = '0;
		endcase
	end

endmodule

// ==== design/smpc_rtc.sv ====
module smpc_rtc #(
	parameter int unsigned SEC_DIV = 4000000
) (
	input  logic                     CLK,
	input  logic                     RST_N,
	output smpc_cmd_pkg::bcd_time_t  rtc_time
);

	localparam int unsigned CW = (SEC_DIV > 1) ? $clog2(SEC_DIV) : 1;

	logic [CW-1:0] div_cnt;
	logic          tick;
	logic [8:0]    sec_n, min_n, hour_n, day_n;  // {carry, next value}

	// One BCD step, wraps from last to first
	function automatic logic [8:0] bcd_step(input logic [7:0] v, input logic [7:0] last,
			input logic [7:0] first);
		if (v == last)
			bcd_step = {1'b1, first};
		else if (v[3:0] == 4'd9)
			bcd_step = {1'b0, v[7:4] + 4'd1, 4'd0};
		else
			bcd_step = {1'b0, v[7:4], v[3:0] + 4'd1};
	endfunction

	assign tick   = div_cnt == CW'(SEC_DIV - 1);
	assign sec_n  = bcd_step(rtc_time.sec, 8'h59, 8'h00);
	assign min_n  = bcd_step(rtc_time.min, 8'h59, 8'h00);
	assign hour_n = bcd_step(rtc_time.hour, 8'h23, 8'h00);
	assign day_n  = bcd_step(rtc_time.day, 8'h31, 8'h01);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			div_cnt  <= '0;
			rtc_time <= '0;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick) begin
				rtc_time.sec <= sec_n[7:0];
				if (sec_n[8])
					rtc_time.min <= min_n[7:0];
				if (sec_n[8] && min_n[8])
					rtc_time.hour <= hour_n[7:0];
				if (sec_n[8] && min_n[8] && hour_n[8])
					rtc_time.day <= day_n[7:0];
			end
		end
	end

endmodule

// ==== design/smpc_cmd_ctrl.sv ====
module smpc_cmd_ctrl (
	input  logic                        CLK,
	input  logic                        RST_N,
	input  logic                        cmd_go,
	input  smpc_cmd_pkg::cmd_t          comreg,
	input  smpc_bus_pkg::ireg_t         ireg,
	output smpc_cmd_pkg::reset_lines_t  reset_lines,
	output logic                        mirq_n,
	output logic [2:0]                  sr_hi,
	output logic                        cmd_done,
	output logic                        oreg_we,
	output smpc_bus_pkg::oreg_idx_t     oreg_wa,
	output smpc_bus_pkg::oreg_idx_t     oreg_sel,
	output logic                        smem_load,
	output logic                        set_ste,
	output logic                        res_enable,
	output logic                        res_disable
);
	import smpc_bus_pkg::*;
	import smpc_cmd_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		START,
		WAIT,
		EXEC,
		INTBACK_FILL,
		END
	} state_t;

	state_t    state;
	wait_t     wait_cnt;
	oreg_idx_t fill_idx;
	logic      status_intback;

	function automatic wait_t wait_time(input cmd_t c);
		case (c)
			CMD_MSHON, CMD_SSHON, CMD_SSHOFF,
			CMD_SNDON, CMD_SNDOFF:             wait_time = WAIT_SHORT;
			CMD_CDON, CMD_CDOFF, CMD_SETSMEM:  wait_time = WAIT_CD;
			CMD_SYSRES:                        wait_time = WAIT_SYSRES;
			CMD_INTBACK:                       wait_time = WAIT_INTBACK;
			CMD_SETTIME:                       wait_time = WAIT_SETTIME;
			CMD_NMIREQ, CMD_RESENAB,
			CMD_RESDISA:                       wait_time = WAIT_NMI;
			default:                           wait_time = 16'd1;  // unknown code
		endcase
	endfunction

	// Status INTBACK only, peripheral data is not supported
	assign status_intback = comreg == CMD_INTBACK && ireg.ireg0[0] && ireg.ireg2 == 8'hF0;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state       <= IDLE;
			wait_cnt    <= '0;
			fill_idx    <= '0;
			reset_lines <= RESET_LINES_INIT;
			mirq_n      <= 1'b1;
			sr_hi       <= '0;
		end else begin
			mirq_n <= 1'b1;
			case (state)
				IDLE: begin
					if (cmd_go)
						state <= START;
				end
				START: begin
					wait_cnt <= wait_time(comreg) - 16'd1;
					fill_idx <= '0;
					state    <= WAIT;
				end
				WAIT: begin
					if (wait_cnt == '0)
						state <= EXEC;
					else
						wait_cnt <= wait_cnt - 16'd1;
				end
				EXEC: begin
					case (comreg)
						CMD_MSHON: begin
							reset_lines.mshres_n <= 1'b1;
							reset_lines.mshnmi_n <= 1'b1;
						end
						CMD_SSHON: begin
							reset_lines.sshres_n <= 1'b1;
							reset_lines.sshnmi_n <= 1'b1;
						end
						CMD_SSHOFF: reset_lines.sshres_n <= 1'b0;
						CMD_SNDON:  reset_lines.sndres_n <= 1'b1;
						CMD_SNDOFF: reset_lines.sndres_n <= 1'b0;
						CMD_CDON:   reset_lines.cdres_n <= 1'b1;
						CMD_CDOFF:  reset_lines.cdres_n <= 1'b0;
						CMD_SYSRES: reset_lines <= '0;
						CMD_NMIREQ: reset_lines.mshnmi_n <= 1'b0;
						default: ;
					endcase
					if (status_intback) begin
						fill_idx <= fill_idx + 5'd1;  // byte 0 written here
						state    <= INTBACK_FILL;
					end else begin
						state <= END;
					end
				end
				INTBACK_FILL: begin
					fill_idx <= fill_idx + 5'd1;
					if (fill_idx == 5'd31) begin
						sr_hi  <= 3'b010;
						mirq_n <= 1'b0;
						state  <= END;
					end
				end
				END: begin
					if (comreg == CMD_SYSRES)
						reset_lines <= '1;
					if (comreg == CMD_NMIREQ)
						reset_lines.mshnmi_n <= 1'b1;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign cmd_done = state == END;
	assign oreg_we  = state == EXEC || state == INTBACK_FILL;
	assign oreg_sel = (state == INTBACK_FILL || status_intback) ? fill_idx : 5'd31;
	assign oreg_wa  = oreg_sel;

	assign smem_load   = state == EXEC && comreg == CMD_SETSMEM;
	assign set_ste     = state == EXEC && comreg == CMD_SETTIME;
	assign res_enable  = state == EXEC && comreg == CMD_RESENAB;
	assign res_disable = state == EXEC && comreg == CMD_RESDISA;

endmodule

// ==== design/smpc_host_regs.sv ====
module smpc_host_regs (
	input  logic                     CLK,
	input  logic                     RST_N,
	input  smpc_bus_pkg::reg_addr_t  a,
	input  smpc_bus_pkg::byte_t      di,
	input  logic                     cs_n,
	input  logic                     rw_n,
	input  smpc_bus_pkg::byte_t      oreg_q,
	input  logic                     cmd_done,
	input  logic [2:0]               sr_hi,
	output smpc_bus_pkg::byte_t      do_byte,
	output smpc_bus_pkg::ireg_t      ireg,
	output smpc_cmd_pkg::cmd_t       comreg,
	output logic                     cmd_go,
	output smpc_bus_pkg::oreg_idx_t  oreg_ra
);
	import smpc_bus_pkg::*;
	import smpc_cmd_pkg::*;

	logic       rw_s1, rw_s2;
	logic       cs_s1, cs_s2;
	logic       wr_edge;
	logic       rd_edge;
	logic [6:0] addr;
	logic       sf;
	byte_t      sr;

	assign addr    = {a, 1'b1};
	assign wr_edge = !rw_s1 && rw_s2 && !cs_s1;  // RW_N fall with CS_N low
	assign rd_edge = !cs_s1 && cs_s2 && rw_s1;   // CS_N fall in read mode
	assign sr      = {sr_hi, 1'b0, ireg.ireg1[7:4]};
	assign oreg_ra = oreg_idx_t'(a - 6'h10);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rw_s1   <= 1'b1;
			rw_s2   <= 1'b1;
			cs_s1   <= 1'b1;
			cs_s2   <= 1'b1;
			ireg    <= '0;
			comreg  <= CMD_MSHON;
			cmd_go  <= 1'b0;
			sf      <= 1'b0;
			do_byte <= '0;
		end else begin
			rw_s1  <= rw_n;
			rw_s2  <= rw_s1;
			cs_s1  <= cs_n;
			cs_s2  <= cs_s1;
			cmd_go <= 1'b0;

			if (cmd_done)
				sf <= 1'b0;

			if (wr_edge) begin
				case (addr)
					ADDR_IREG0: ireg.ireg0 <= di;
					ADDR_IREG1: ireg.ireg1 <= di;
					ADDR_IREG2: ireg.ireg2 <= di;
					ADDR_IREG3: ireg.ireg3 <= di;
					ADDR_COMREG: begin
						comreg <= cmd_t'(di);
						cmd_go <= 1'b1;
					end
					ADDR_SF: if (di[0]) sf <= 1'b1;  // host sets SF, sequencer clears it
					default: ;
				endcase
			end

			if (rd_edge) begin
				if (addr >= ADDR_OREG_BASE && addr <= ADDR_OREG_LAST)
					do_byte <= oreg_q;
				else if (addr == ADDR_SR)
					do_byte <= sr;
				else if (addr == ADDR_SF)
					do_byte <= {7'd0, sf};
				else
					do_byte <= '0;
			end
		end
	end

endmodule

// ==== design/smpc_cmd_pkg.sv ====
package smpc_cmd_pkg;

	typedef enum logic [7:0] {
		CMD_MSHON   = 8'h00,
		CMD_SSHON   = 8'h02,
		CMD_SSHOFF  = 8'h03,
		CMD_SNDON   = 8'h06,
		CMD_SNDOFF  = 8'h07,
		CMD_CDON    = 8'h08,
		CMD_CDOFF   = 8'h09,
		CMD_SYSRES  = 8'h0D,
		CMD_INTBACK = 8'h10,
		CMD_SETTIME = 8'h16,
		CMD_SETSMEM = 8'h17,
		CMD_NMIREQ  = 8'h18,
		CMD_RESENAB = 8'h19,
		CMD_RESDISA = 8'h1A
	} cmd_t;

	typedef logic [15:0] wait_t;

	// Command wait times in clock cycles
	localparam wait_t WAIT_SHORT   = 16'd120;
	localparam wait_t WAIT_CD      = 16'd159;
	localparam wait_t WAIT_SYSRES  = 16'd400;
	localparam wait_t WAIT_INTBACK = 16'd500;
	localparam wait_t WAIT_SETTIME = 16'd279;
	localparam wait_t WAIT_NMI     = 16'd127;

	typedef struct packed {
		logic mshres_n;
		logic mshnmi_n;
		logic sshres_n;
		logic sshnmi_n;
		logic sysres_n;
		logic sndres_n;
		logic cdres_n;
	} reset_lines_t;

	// Slave CPU and sound held in reset at power up
	localparam reset_lines_t RESET_LINES_INIT = 7'b1101101;

	typedef struct packed {
		logic [7:0] sec;
		logic [7:0] min;
		logic [7:0] hour;
		logic [7:0] day;
	} bcd_time_t;

	localparam logic [7:0] STATUS_YEAR_HI = 8'h20;
	localparam logic [7:0] STATUS_YEAR_LO = 8'h22;
	localparam logic [7:0] STATUS_MONTH   = 8'h01;

endpackage

// ==== design/smpc_bus_pkg.sv ====
package smpc_bus_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [5:0] reg_addr_t;  // A[6:1]
	typedef logic [4:0] oreg_idx_t;

	typedef struct packed {
		byte_t ireg3;
		byte_t ireg2;
		byte_t ireg1;
		byte_t ireg0;
	} ireg_t;

	// Full odd byte addresses, compared against {A[6:1], 1'b1}
	localparam logic [6:0] ADDR_IREG0     = 7'h01;
	localparam logic [6:0] ADDR_IREG1     = 7'h03;
	localparam logic [6:0] ADDR_IREG2     = 7'h05;
	localparam logic [6:0] ADDR_IREG3     = 7'h07;
	localparam logic [6:0] ADDR_COMREG    = 7'h1F;
	localparam logic [6:0] ADDR_OREG_BASE = 7'h21;
	localparam logic [6:0] ADDR_OREG_LAST = 7'h5F;
	localparam logic [6:0] ADDR_SR        = 7'h61;
	localparam logic [6:0] ADDR_SF        = 7'h63;

endpackage
